//--- design/aluUnit.sv
`timescale 1ns/100ps

module aluUnit import corePkg::*; (
   input  decoded_t decoded,
   input  word_t    rs1Data,
   input  word_t    rs2Data,
   output word_t    aluResult
);

   word_t      opB;
   logic [4:0] shamt;

   assign opB   = decoded.useImm ? decoded.imm : rs2Data;
   assign shamt = opB[4:0];   // low 5 bits only

   always_comb begin
      case (decoded.aluOp)
         aluAdd:  aluResult = rs1Data + opB;
         aluSub:  aluResult = rs1Data - opB;
         aluXor:  aluResult = rs1Data ^ opB;
         aluOr:   aluResult = rs1Data | opB;
         aluAnd:  aluResult = rs1Data & opB;
         aluSlt:  aluResult = word_t'($signed(rs1Data) < $signed(opB));
         aluSltu: aluResult = word_t'(rs1Data < opB);
         aluSll:  aluResult = rs1Data << shamt;
         aluSrl:  aluResult = rs1Data >> shamt;
         aluSra:  aluResult = word_t'($signed(rs1Data) >>> shamt);
         default: aluResult = '0;
      endcase
   end

endmodule

//--- design/busSequencer.sv
`timescale 1ns/100ps
`include "core_cfg.svh"

module busSequencer import corePkg::*; (
   input  logic       clk,
   input  logic       rstn,
   input  logic       start,
   input  logic       rVld,
   input  word_t      rData,
   input  decoded_t   decoded,
   input  word_t      aluResult,
   input  word_t      rs2Data,
   output instrWord_t instr,
   output memReq_t    memReq,
   output regWrite_t  regWrite,
   output logic       halted
);

   typedef enum logic [1:0] {sHalt, sFetch, sExec, sMem} state_e;

   state_e     state;
   word_t      pc;
   instrWord_t ir;
   logic       stop;
   logic       aluWb;

   // halt opcode or anything undecodable
   assign stop  = decoded.invalid || decoded.opClass == opHalt;
   assign aluWb = decoded.opClass inside {opAlu, opLui};

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state  <= sHalt;
         pc     <= `RESET_PC;
         memReq <= '0;
      end else begin
         case (state)
            sHalt: begin
               if (start) begin
                  state <= sFetch;
               end
            end
            sFetch: begin
               if (!memReq.req) begin
                  memReq.req  <= 1'b1;   // only after start or a memory phase
                  memReq.wEn  <= 1'b0;
                  memReq.addr <= pc;
               end else if (rVld) begin
                  memReq.req <= 1'b0;
                  pc         <= pc + 1'b1;
                  state      <= sExec;
               end
            end
            sExec: begin
               if (stop) begin
                  state <= sHalt;
               end else if (decoded.opClass inside {opLoad, opStore}) begin
                  memReq.req   <= 1'b1;
                  memReq.wEn   <= decoded.opClass == opStore;
                  memReq.addr  <= aluResult;   // rs1 + imm
                  memReq.wData <= rs2Data;
                  state        <= sMem;
               end else begin
                  // ALU / LUI, fetch next right away
                  memReq.req  <= 1'b1;
                  memReq.wEn  <= 1'b0;
                  memReq.addr <= pc;
                  state       <= sFetch;
               end
            end
            default: begin
               if (rVld) begin
                  memReq.req <= 1'b0;
                  memReq.wEn <= 1'b0;
                  state      <= sFetch;
               end
            end
         endcase
      end
   end

   // instruction register
   always_ff @(posedge clk) begin
      if (state == sFetch && memReq.req && rVld) begin
         ir <= rData;
      end
   end

   // writeback select
   always_comb begin
      regWrite.addr = decoded.rd;
      regWrite.data = (decoded.opClass == opLui) ? decoded.imm : aluResult;
      regWrite.en   = state == sExec && aluWb && !stop;
      if (state == sMem) begin
         regWrite.data = rData;                 // load data
         regWrite.en   = rVld && !memReq.wEn;
      end
   end

   assign instr  = ir;
   assign halted = state == sHalt;

endmodule

//--- design/corePkg.sv
`include "core_cfg.svh"

package corePkg;

   typedef logic [`XLEN-1:0]       word_t;
   typedef logic [`REG_ADDR_W-1:0] regAddr_t;

   typedef struct packed {
      logic [6:0] funct7;
      regAddr_t   rs2;
      regAddr_t   rs1;
      logic [2:0] funct3;
      regAddr_t   rd;
      logic [6:0] opcode;
   } rType_t;

   typedef struct packed {
      logic [11:0] imm;
      regAddr_t    rs1;
      logic [2:0]  funct3;
      regAddr_t    rd;
      logic [6:0]  opcode;
   } iType_t;

   typedef struct packed {
      logic [6:0] immHi;
      regAddr_t   rs2;
      regAddr_t   rs1;
      logic [2:0] funct3;
      logic [4:0] immLo;
      logic [6:0] opcode;
   } sType_t;

   typedef struct packed {
      logic [19:0] imm;
      regAddr_t    rd;
      logic [6:0]  opcode;
   } uType_t;

   // one fetched word, four views
   typedef union packed {
      rType_t rType;
      iType_t iType;
      sType_t sType;
      uType_t uType;
   } instrWord_t;

   typedef enum logic [3:0] {
      aluAdd, aluSub, aluXor, aluOr, aluAnd,
      aluSlt, aluSltu, aluSll, aluSrl, aluSra
   } aluOp_e;

   typedef enum logic [2:0] {opAlu, opLui, opLoad, opStore, opHalt} opClass_e;

   typedef struct packed {
      opClass_e opClass;
      aluOp_e   aluOp;
      logic     useImm;
      regAddr_t rd;
      regAddr_t rs1;
      regAddr_t rs2;
      word_t    imm;     // already sign-extended
      logic     invalid;
   } decoded_t;

   typedef struct packed {
      logic  req;
      logic  wEn;
      word_t addr;
      word_t wData;
   } memReq_t;

   typedef struct packed {
      logic     en;
      regAddr_t addr;
      word_t    data;
   } regWrite_t;

endpackage

//--- design/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

`define XLEN        32
`define REG_ADDR_W  5

// major opcodes, instruction bits [6:0]
`define OPC_OP      7'b0110011
`define OPC_OPIMM   7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011

`define OPC_HALT    7'h7F

`define RESET_PC    32'h0000_0000 // word index of first fetch

`endif

//--- design/instrDecoder.sv
`timescale 1ns/100ps
`include "core_cfg.svh"

module instrDecoder import corePkg::*; (
   input  instrWord_t instr,
   output decoded_t   decoded
);

   // alt picks SUB / SRA, funct7 bit 5
   function automatic aluOp_e f3ToAluOp(input logic [2:0] funct3, input logic alt);
      case (funct3)
         3'b000:  return alt ? aluSub : aluAdd;
         3'b001:  return aluSll;
         3'b010:  return aluSlt;
         3'b011:  return aluSltu;
         3'b100:  return aluXor;
         3'b101:  return alt ? aluSra : aluSrl;
         3'b110:  return aluOr;
         default: return aluAnd;
      endcase
   endfunction

   function automatic word_t sext12(input logic [11:0] imm12);
      return {{(`XLEN-12){imm12[11]}}, imm12};
   endfunction

   always_comb begin
      decoded         = '0;
      decoded.opClass = opHalt;
      decoded.aluOp   = aluAdd;
      case (instr.rType.opcode)
         `OPC_OP: begin
            decoded.opClass = opAlu;
            decoded.rd      = instr.rType.rd;
            decoded.rs1     = instr.rType.rs1;
            decoded.rs2     = instr.rType.rs2;
            decoded.aluOp   = f3ToAluOp(instr.rType.funct3, instr.rType.funct7[5]);
            if (instr.rType.funct7 == 7'h20) begin
               decoded.invalid = !(instr.rType.funct3 inside {3'b000, 3'b101});
            end else if (instr.rType.funct7 != 7'h00) begin
               decoded.invalid = 1'b1;
            end
         end
         `OPC_OPIMM: begin
            decoded.opClass = opAlu;
            decoded.useImm  = 1'b1;
            decoded.rd      = instr.iType.rd;
            decoded.rs1     = instr.iType.rs1;
            if (instr.iType.funct3 inside {3'b001, 3'b101}) begin
               // shift immediates, funct7 sits in imm[11:5]
               decoded.imm     = word_t'(instr.iType.imm[4:0]);
               decoded.aluOp   = f3ToAluOp(instr.iType.funct3, instr.iType.imm[10]);
               decoded.invalid = !(instr.iType.imm[11:5] == 7'h00 ||
                                   (instr.iType.imm[11:5] == 7'h20 &&
                                    instr.iType.funct3 == 3'b101));
            end else begin
               decoded.imm   = sext12(instr.iType.imm);
               decoded.aluOp = f3ToAluOp(instr.iType.funct3, 1'b0);
            end
         end
         `OPC_LUI: begin
            decoded.opClass = opLui;
            decoded.rd      = instr.uType.rd;
            decoded.imm     = {instr.uType.imm, 12'b0};
         end
         `OPC_LOAD: begin
            decoded.opClass = opLoad;
            decoded.useImm  = 1'b1;   // address = rs1 + imm
            decoded.rd      = instr.iType.rd;
            decoded.rs1     = instr.iType.rs1;
            decoded.imm     = sext12(instr.iType.imm);
            decoded.invalid = instr.iType.funct3 != 3'b010; // LW only
         end
         `OPC_STORE: begin
            decoded.opClass = opStore;
            decoded.useImm  = 1'b1;
            decoded.rs1     = instr.sType.rs1;
            decoded.rs2     = instr.sType.rs2;
            decoded.imm     = sext12({instr.sType.immHi, instr.sType.immLo});
            decoded.invalid = instr.sType.funct3 != 3'b010; // SW only
         end
         `OPC_HALT: begin
            decoded.opClass = opHalt;
         end
         default: begin
            decoded.invalid = 1'b1;
         end
      endcase
   end

endmodule

//--- design/regFile.sv
`timescale 1ns/100ps

module regFile import corePkg::*; (
   input  logic      clk,
   input  logic      rstn,
   input  regAddr_t  rs1,
   input  regAddr_t  rs2,
   input  regWrite_t regWrite,
   output word_t     rs1Data,
   output word_t     rs2Data
);

   localparam int NUM_REGS = 1 << $bits(regAddr_t);

   word_t regs [NUM_REGS];

   // x0 is cleared by reset and never written
   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (regWrite.en && regWrite.addr != '0) begin
         regs[regWrite.addr] <= regWrite.data;
      end
   end

   assign rs1Data = regs[rs1];
   assign rs2Data = regs[rs2];

endmodule

//--- design/rvCore.sv
`timescale 1ns/100ps

module rvCore import corePkg::*; (
   input  logic    clk,
   input  logic    rstn,
   input  logic    start,
   input  logic    rVld,
   input  word_t   rData,
   output memReq_t memReq,
   output logic    halted
);

   instrWord_t instr;
   decoded_t   decoded;
   word_t      rs1Data;
   word_t      rs2Data;
   word_t      aluResult;
   regWrite_t  regWrite;

   busSequencer i_busSequencer (
      .clk       (clk),
      .rstn      (rstn),
      .start     (start),
      .rVld      (rVld),
      .rData     (rData),
      .decoded   (decoded),
      .aluResult (aluResult),
      .rs2Data   (rs2Data),
      .instr     (instr),
      .memReq    (memReq),
      .regWrite  (regWrite),
      .halted    (halted)
   );

   instrDecoder i_instrDecoder (
      .instr   (instr),
      .decoded (decoded)
   );

   aluUnit i_aluUnit (
      .decoded   (decoded),
      .rs1Data   (rs1Data),
      .rs2Data   (rs2Data),
      .aluResult (aluResult)
   );

   regFile i_regFile (
      .clk      (clk),
      .rstn     (rstn),
      .rs1      (decoded.rs1),
      .rs2      (decoded.rs2),
      .regWrite (regWrite),
      .rs1Data  (rs1Data),
      .rs2Data  (rs2Data)
   );

endmodule

//--- flist.f
+incdir+design
design/corePkg.sv
design/instrDecoder.sv
design/aluUnit.sv
design/regFile.sv
design/busSequencer.sv
design/rvCore.sv
testbench/rvCore_assert.sv
testbench/rvCoreTb.sv

//--- run.sh
#!/bin/sh
# build and run the rvCore testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module rvCoreTb -o simv
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
   exit 1
fi
if ! grep -q "ALL TESTS PASSED" "$LOG"; then
   echo "no pass message in $LOG"
   exit 1
fi
exit 0

//--- testbench/rvCoreTb.sv
`timescale 1ns/100ps

module rvCoreTb import corePkg::*; ;

   localparam int MEM_WORDS = 256;
   localparam int MARGIN    = 200;

   logic    clk;
   logic    rstn  = 1'b0;
   logic    start = 1'b0;
   logic    rVld  = 1'b0;
   word_t   rData = '0;
   memReq_t memReq;
   logic    halted;

   rvCore i_rvCore (
      .clk    (clk),
      .rstn   (rstn),
      .start  (start),
      .rVld   (rVld),
      .rData  (rData),
      .memReq (memReq),
      .halted (halted)
   );

   bind rvCore rvCore_assert i_rvCoreAssert (
      .clk      (clk),
      .rstn     (rstn),
      .memReq   (memReq),
      .rVld     (rVld),
      .halted   (halted),
      .regWrite (regWrite)
   );

   int    progRun[$];
   word_t progAddr[$];
   word_t progData[$];
   int    expRun[$];
   word_t expAddr[$];
   word_t expData[$];
   int    expTest[$];

   string testNames [8] = '{"", "rType", "immediate", "lui", "loadStore",
                            "regZero", "haltOpcode", "invalidFunct7"};
   int    testErrs [8];
   int    testChecks [8];
   int    errCount   = 0;
   int    passCount  = 0;
   int    failCount  = 0;

   word_t       mem [MEM_WORDS];
   logic [31:0] lcgState   = 32'h87f5;
   int          waitCnt    = 0;
   logic        busy       = 1'b0;
   int          reqCount   = 0;
   int          runIdx     = 0;
   int          expPtr     = 0;
   int          storeCount = 0;
   int          curTest    = 0;
   int          cycles     = 0;
   int          cycleLimit = 0;

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function logic [31:0] nextRand();
      lcgState = lcgState * 32'd1103515245 + 32'd12345;
      return lcgState;
   endfunction

   task checkWord(input string name, input word_t exp, input word_t act);
      testChecks[curTest]++;
      if (exp !== act) begin
         $display("[ERROR] %s expected %h actual %h", name, exp, act);
         testErrs[curTest]++;
         errCount++;
      end
   endtask

   task checkHalt(input string name, input logic exp, input logic act);
      testChecks[curTest]++;
      if (exp !== act) begin
         $display("[ERROR] %s halted expected %b actual %b", name, exp, act);
         testErrs[curTest]++;
         errCount++;
      end
   endtask

   task reportTest(input int t);
      if (testErrs[t] == 0) begin
         passCount++;
         $display("test %s: ok, %0d checks", testNames[t], testChecks[t]);
      end else begin
         failCount++;
         $display("test %s: %0d of %0d checks wrong", testNames[t], testErrs[t],
                  testChecks[t]);
      end
   endtask

   // compare one store against the next expected record
   task recordStore(input word_t addr, input word_t data);
      int t;
      storeCount++;
      if (expPtr >= expAddr.size() || expRun[expPtr] != runIdx) begin
         $display("store to %h with %h was not expected", addr, data);
         errCount++;
      end else begin
         t = expTest[expPtr];
         if (t != curTest) begin
            if (curTest != 0) reportTest(curTest);
            curTest = t;
         end
         checkWord({testNames[t], " addr"}, expAddr[expPtr], addr);
         checkWord({testNames[t], " data"}, expData[expPtr], data);
         expPtr++;
      end
   endtask

   // memory with 1 to 4 cycles of response delay
   always @(posedge clk) begin : memModel
      logic [31:0] r;
      if (!rstn) begin
         rVld <= 1'b0;
         busy <= 1'b0;
      end else if (rVld) begin
         rVld <= 1'b0;
         busy <= 1'b0;
      end else if (memReq.req && !busy) begin
         r = nextRand();
         busy     <= 1'b1;
         waitCnt  <= 1 + int'(r[17:16]);
         reqCount <= reqCount + 1;
      end else if (busy) begin
         if (waitCnt <= 1) begin
            rVld <= 1'b1;
            if (memReq.addr >= MEM_WORDS) begin
               $display("access to address %h is outside the memory", memReq.addr);
               errCount++;
            end else if (memReq.wEn) begin
               mem[memReq.addr[7:0]] <= memReq.wData;
               recordStore(memReq.addr, memReq.wData);
            end else begin
               rData <= mem[memReq.addr[7:0]];
            end
         end else begin
            waitCnt <= waitCnt - 1;
         end
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycleLimit > 0 && cycles > cycleLimit) begin
         $display("timeout: core did not halt within %0d cycles", cycleLimit);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   task loadStimulus;
      int          fd;
      int          code;
      int          run;
      int          t;
      string       line;
      string       tag;
      logic [31:0] a;
      logic [31:0] d;
      fd  = $fopen("testbench/rvCore_stimulus.txt", "r");
      run = 0;
      if (fd == 0) begin
         $display("cannot open the stimulus file");
      end else begin
         while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
               t    = 0;
               code = $sscanf(line, "%s %h %h %d", tag, a, d, t);
               if (tag == "R") begin
                  run = int'(a);
               end else if (tag == "P") begin
                  progRun.push_back(run);
                  progAddr.push_back(a);
                  progData.push_back(d);
               end else if (tag == "E") begin
                  expRun.push_back(run);
                  expAddr.push_back(a);
                  expData.push_back(d);
                  expTest.push_back(t);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   task runProgram(input int run);
      int   haltTest;
      int   expCount;
      int   reqBefore;
      logic haltedReset;
      logic haltedStart;
      haltTest = (run == 0) ? 6 : 7;
      expCount = 0;
      expPtr   = -1;
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = 32'hA5A5_0000 ^ (i * 32'h0001_0101);   // fill pattern
      end
      foreach (progAddr[i]) begin
         if (progRun[i] == run) mem[progAddr[i][7:0]] = progData[i];
      end
      foreach (expRun[i]) begin
         if (expRun[i] == run) begin
            expCount++;
            if (expPtr < 0) expPtr = i;
         end
      end
      if (expPtr < 0) expPtr = expRun.size();
      runIdx     = run;
      storeCount = 0;
      curTest    = 0;

      @(posedge clk);
      rstn <= 1'b0;
      repeat (4) @(posedge clk);
      rstn  <= 1'b1;
      @(negedge clk);
      haltedReset = halted;   // out of reset, not started yet
      @(posedge clk);
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      @(negedge clk);
      haltedStart = halted;   // dropped on the start edge
      while (halted !== 1'b1) @(negedge clk);

      reqBefore = reqCount;
      repeat (10) @(negedge clk);   // core must stay idle
      if (curTest != 0 && curTest != haltTest) reportTest(curTest);
      curTest = haltTest;
      checkHalt({testNames[haltTest], " reset"}, 1'b1, haltedReset);
      checkHalt({testNames[haltTest], " start"}, 1'b0, haltedStart);
      checkHalt(testNames[haltTest], 1'b1, halted);
      if (reqCount != reqBefore) begin
         $display("a request was made after the core halted");
         testErrs[haltTest]++;
         errCount++;
      end
      if (storeCount != expCount) begin
         $display("%0d stores seen but %0d expected", storeCount, expCount);
         testErrs[haltTest]++;
         errCount++;
      end
      reportTest(haltTest);
   endtask

   initial begin
      loadStimulus();
      cycleLimit = progAddr.size() * 3 * 5 + MARGIN;
      runProgram(0);
      runProgram(1);
      $display("tests passed %0d, failed %0d, errors %0d", passCount, failCount, errCount);
      if (errCount == 0 && failCount == 0 && progAddr.size() > 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- testbench/rvCore_assert.sv
`timescale 1ns/100ps

module rvCore_assert import corePkg::*; (
   input logic      clk,
   input logic      rstn,
   input memReq_t   memReq,
   input logic      rVld,
   input logic      halted,
   input regWrite_t regWrite
);

   // request held until the memory answers
   reqStable: assert property (@(posedge clk) disable iff (!rstn)
      (memReq.req && !rVld) |=> $stable(memReq))
      else $error("request fields changed while waiting for rVld");

   noReqWhileHalted: assert property (@(posedge clk) disable iff (!rstn)
      $rose(memReq.req) |-> !halted)
      else $error("request raised while core is halted");

   noWriteOnStore: assert property (@(posedge clk) disable iff (!rstn)
      !(regWrite.en && memReq.req && memReq.wEn))
      else $error("register write during a pending store");

endmodule

//--- testbench/rvCore_stimulus.txt
# P addr word = program word, E addr data test = expected store, R n = start of run n
# addresses are word indices in hex, test is the test number
R 0
P 00 04000513
P 01 06400093
P 02 FF900113
P 03 00300193
P 04 002082B3
P 05 00552023
P 06 402082B3
P 07 005520A3
P 08 0020C2B3
P 09 00552123
P 0A 0020E2B3
P 0B 005521A3
P 0C 0020F2B3
P 0D 00552223
P 0E 0020A2B3
P 0F 005522A3
P 10 0020B2B3
P 11 00552323
P 12 003112B3
P 13 005523A3
P 14 003152B3
P 15 00552423
P 16 403152B3
P 17 005524A3
P 18 F3808293
P 19 00552523
P 1A 40215293
P 1B 005525A3
P 1C FFF0B293
P 1D 00552623
P 1E 00F14293
P 1F 005526A3
P 20 FFD12293
P 21 00552723
P 22 ABCDE337
P 23 006527A3
P 24 00850593
P 25 0015A623
P 26 00C5A383
P 27 00752823
P 28 03700013
P 29 000528A3
P 2A 0000007F
E 40 0000005D 1
E 41 0000006B 1
E 42 FFFFFF9D 1
E 43 FFFFFFFD 1
E 44 00000060 1
E 45 00000000 1
E 46 00000001 1
E 47 FFFFFFC8 1
E 48 1FFFFFFF 1
E 49 FFFFFFFF 1
E 4A FFFFFF9C 2
E 4B FFFFFFFE 2
E 4C 00000001 2
E 4D FFFFFFF6 2
E 4E 00000001 2
E 4F ABCDE000 3
E 54 00000064 4
E 50 00000064 4
E 51 00000000 5
R 1
P 00 06400093
P 01 04000513
P 02 00152023
P 03 022082B3
P 04 005520A3
P 05 0000007F
E 40 00000064 7
